//--- board_cfg.svh
/*
 * board timing configuration
 * cycle counts for the UART bit period, key debounce and display scan
 */
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// clock cycles per UART bit, must be even
`define BIT_CYCLES 16

// stable cycles before a key level is accepted
`define DEBOUNCE_CYCLES 8

// cycles each display digit stays selected
`define SCAN_CYCLES 4

`endif

//--- board_pkg.sv
/*
 * board_pkg
 * shared types for the byte datapath, the keys and the display
 */
package board_pkg;

	// one UART payload byte
	typedef logic [7:0] byte_t;

	// one bit per push key
	typedef logic [3:0] key_vec_t;

	// display code: 0..15 hex, 16 blank, 17 dash
	typedef logic [4:0] digit_t;

	// eight codes, index 7 is the leftmost digit
	typedef digit_t [7:0] digit_vec_t;

	// active-low segments, a in bit 0, point in bit 7
	typedef logic [7:0] seg_t;

	localparam digit_t DIG_F     = 5'd15;
	localparam digit_t DIG_BLANK = 5'd16;
	localparam digit_t DIG_DASH  = 5'd17;

endpackage

//--- uart_byte_if.sv
/*
 * uart_byte_if
 * one byte with valid/ready handshake and a framing error flag
 */
`timescale 1ns/1ns

interface uart_byte_if;

	logic [7:0] data;
	logic       valid;
	logic       ready;
	logic       frame_err;

	modport src (output data, output valid, output frame_err, input ready);
	modport snk (input data, input valid, input frame_err, output ready);

endinterface

//--- uart_rx.sv
/*
 * uart_rx
 * 8N1 serial receiver, start bit confirmed at half a bit period,
 * data bits sampled mid-bit, low stop bit flagged as framing error
 */
`timescale 1ns/1ns
`include "board_cfg.svh"

module uart_rx import board_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	input  logic     rx_line,
	uart_byte_if.src out
);

	localparam int HALF_CYCLES = `BIT_CYCLES / 2;
	localparam int CNT_W = $clog2(`BIT_CYCLES);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic             rx_s1;
	logic             rx_s2;
	logic             rx_prev;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic             bit_end;
	byte_t            shreg;
	logic             valid_q;
	logic             err_q;

	assign bit_end = (cnt == CNT_W'(`BIT_CYCLES - 1));

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1   <= 1'b1;
			rx_s2   <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_s1   <= rx_line;
			rx_s2   <= rx_s1;
			rx_prev <= rx_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					// falling edge only, a stuck low line does not retrigger
					if (rx_prev && !rx_s2)
						state <= RX_START;
				end
				RX_START: begin
					if (cnt == CNT_W'(HALF_CYCLES - 1)) begin
						cnt   <= '0;
						state <= rx_s2 ? RX_IDLE : RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (bit_end) begin
						cnt     <= '0;
						err_q   <= !rx_s2;
						valid_q <= 1'b1;
						state   <= RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end)
			shreg <= {rx_s2, shreg[7:1]};
	end

	assign out.data      = shreg;
	assign out.valid     = valid_q;
	assign out.frame_err = err_q;

endmodule

//--- uart_tx.sv
/*
 * uart_tx
 * 8N1 serial transmitter, takes one byte while idle and
 * shifts out start, data and stop bits
 */
`timescale 1ns/1ns
`include "board_cfg.svh"

module uart_tx import board_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	uart_byte_if.snk in,
	output logic     tx_line
);

	localparam int CNT_W = $clog2(`BIT_CYCLES);

	logic [9:0]       shreg;
	logic [CNT_W-1:0] cnt;
	logic [3:0]       bit_cnt;
	logic             busy;

	// back-pressure for the whole frame
	assign in.ready = !busy;

	// shreg fills with ones, so the line rests high
	assign tx_line = shreg[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			shreg   <= '1;
			cnt     <= '0;
			bit_cnt <= '0;
			busy    <= 1'b0;
		end else if (!busy) begin
			if (in.valid && in.ready) begin
				// stop, data lsb first, start
				shreg   <= {1'b1, byte_t'(in.data), 1'b0};
				cnt     <= '0;
				bit_cnt <= '0;
				busy    <= 1'b1;
			end
		end else if (cnt == CNT_W'(`BIT_CYCLES - 1)) begin
			cnt   <= '0;
			shreg <= {1'b1, shreg[9:1]};
			if (bit_cnt == 4'd9)
				busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- key_debounce.sv
/*
 * key_debounce
 * debounces four active-low keys, gives pressed levels and press
 * pulses, toggles one LED per press
 */
`timescale 1ns/1ns
`include "board_cfg.svh"

module key_debounce import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	output logic [3:0] sta_key,
	output logic [3:0] sta_key_pos,
	output logic [7:0] led
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	key_vec_t         key_s1;
	key_vec_t         key_s2;
	key_vec_t         level;
	key_vec_t         pos;
	key_vec_t         led_tog;
	logic [CNT_W-1:0] cnt [4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_s1 <= '1;
			key_s2 <= '1;
		end else begin
			key_s1 <= key_in;
			key_s2 <= key_s1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			level   <= '0;
			pos     <= '0;
			led_tog <= '0;
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				pos[i] <= 1'b0;
				// key_s2 is active low, equal to level means a change
				if (key_s2[i] != level[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
					cnt[i]   <= '0;
					level[i] <= !key_s2[i];
					if (!key_s2[i]) begin
						pos[i]     <= 1'b1;
						led_tog[i] <= !led_tog[i];
					end
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign sta_key     = level;
	assign sta_key_pos = pos;
	assign led         = {level, led_tog};

endmodule

//--- uart_echo_ctrl.sv
/*
 * uart_echo_ctrl
 * queues echo and test-byte requests, echo first, and keeps
 * the last good received byte and the running test byte
 */
`timescale 1ns/1ns

module uart_echo_ctrl import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	uart_byte_if.snk   rx,
	uart_byte_if.src   tx,
	input  logic       send_test,
	output logic [7:0] rx_byte,
	output logic [7:0] test_byte
);

	byte_t echo_data;
	byte_t slot_data;
	logic  echo_pend;
	logic  test_pend;
	logic  slot_valid;
	logic  slot_test;
	logic  rx_good;
	logic  tx_fire;
	logic  slot_load;

	assign rx.ready     = 1'b1;
	assign tx.valid     = slot_valid;
	assign tx.data      = slot_data;
	assign tx.frame_err = 1'b0;

	assign rx_good = rx.valid && rx.ready && !rx.frame_err;
	assign tx_fire = tx.valid && tx.ready;
	// pick only while the transmitter is idle so priority holds
	assign slot_load = !slot_valid && tx.ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			echo_pend  <= 1'b0;
			test_pend  <= 1'b0;
			slot_valid <= 1'b0;
			slot_test  <= 1'b0;
			rx_byte    <= '0;
			test_byte  <= '0;
		end else begin
			if (tx_fire) begin
				slot_valid <= 1'b0;
				if (slot_test)
					test_byte <= test_byte + 1'b1;
			end else if (slot_load) begin
				if (echo_pend) begin
					slot_valid <= 1'b1;
					slot_test  <= 1'b0;
					echo_pend  <= 1'b0;
				end else if (test_pend) begin
					slot_valid <= 1'b1;
					slot_test  <= 1'b1;
					test_pend  <= 1'b0;
				end
			end
			// new requests win over the clears above
			if (rx_good) begin
				echo_pend <= 1'b1;
				rx_byte   <= rx.data;
			end
			if (send_test)
				test_pend <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_good)
			echo_data <= rx.data;
		if (slot_load)
			slot_data <= echo_pend ? echo_data : test_byte;
	end

endmodule

//--- seg_scan.sv
/*
 * seg_scan
 * eight-digit multiplexed seven-segment driver, one digit
 * selected at a time with registered segments and select
 */
`timescale 1ns/1ns
`include "board_cfg.svh"

module seg_scan import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  digit_vec_t digits,
	output seg_t       seg_number,
	output logic [7:0] seg_choice
);

	localparam int SCAN_W = $clog2(`SCAN_CYCLES + 1);

	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        dig_idx;
	logic [2:0]        next_idx;
	logic              scan_end;
	digit_t            cur_code;

	// active-high gfedcba pattern
	function automatic logic [6:0] seg_decode(input digit_t code);
		case (code)
			5'd0:     return 7'h3F;
			5'd1:     return 7'h06;
			5'd2:     return 7'h5B;
			5'd3:     return 7'h4F;
			5'd4:     return 7'h66;
			5'd5:     return 7'h6D;
			5'd6:     return 7'h7D;
			5'd7:     return 7'h07;
			5'd8:     return 7'h7F;
			5'd9:     return 7'h6F;
			5'd10:    return 7'h77;
			5'd11:    return 7'h7C;
			5'd12:    return 7'h39;
			5'd13:    return 7'h5E;
			5'd14:    return 7'h79;
			5'd15:    return 7'h71;
			DIG_DASH: return 7'h40;
			// blank and unused codes
			default:  return 7'h00;
		endcase
	endfunction

	assign scan_end = (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1));
	// outputs follow next_idx so select and dig_idx stay aligned
	assign next_idx = scan_end ? dig_idx + 3'd1 : dig_idx;
	assign cur_code = digits[next_idx];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= '0;
			dig_idx    <= '0;
			seg_number <= '1;
			seg_choice <= 8'hFE;
		end else begin
			scan_cnt   <= scan_end ? '0 : scan_cnt + 1'b1;
			dig_idx    <= next_idx;
			// point bit stays off
			seg_number <= {1'b1, ~seg_decode(cur_code)};
			seg_choice <= ~(8'd1 << next_idx);
		end
	end

endmodule

//--- board_top.sv
/*
 * board_top
 * UART echo with test-byte key, debounced keys with LEDs
 * and a scanned eight-digit display
 */
`timescale 1ns/1ns

module board_top import board_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	output logic [7:0] led,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice,
	input  logic       uart_rx_port,
	output logic       uart_tx_port
);

	uart_byte_if rx_bus();
	uart_byte_if tx_bus();

	logic [3:0] key_pos;
	logic [7:0] rx_byte;
	logic [7:0] test_byte;
	digit_vec_t disp_word;

	// F, blank, dash, test byte, blank, received byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			disp_word <= {DIG_F, {7{DIG_BLANK}}};
		end else begin
			disp_word <= {
				DIG_F,
				DIG_BLANK,
				DIG_DASH,
				{1'b0, test_byte[7:4]},
				{1'b0, test_byte[3:0]},
				DIG_BLANK,
				{1'b0, rx_byte[7:4]},
				{1'b0, rx_byte[3:0]}
			};
		end
	end

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (uart_rx_port),
		.out       (rx_bus.src)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.in        (tx_bus.snk),
		.tx_line   (uart_tx_port)
	);

	key_debounce u_key_debounce (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.key_in      (key_in),
		.sta_key     (),
		.sta_key_pos (key_pos),
		.led         (led)
	);

	// key 0 sends the test byte
	uart_echo_ctrl u_uart_echo_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx_bus.snk),
		.tx        (tx_bus.src),
		.send_test (key_pos[0]),
		.rx_byte   (rx_byte),
		.test_byte (test_byte)
	);

	seg_scan u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.digits     (disp_word),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

//--- board_props.sv
/*
 * board_props
 * reset state and display scan checks on board_top
 */
`timescale 1ns/1ns
`include "board_cfg.svh"

module board_props (
	input logic       sys_clk,
	input logic       sys_rst_n,
	input logic [7:0] led,
	input logic [7:0] seg_number,
	input logic [7:0] seg_choice,
	input logic       uart_tx_port
);

	int         fail_cnt = 0;
	logic [7:0] choice_q;
	int         hold_cnt;

	// cycles the current select has been held
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			choice_q <= 8'hFE;
			hold_cnt <= 0;
		end else begin
			choice_q <= seg_choice;
			if (seg_choice != choice_q)
				hold_cnt <= 1;
			else
				hold_cnt <= hold_cnt + 1;
		end
	end

	a_reset_idle: assert property (@(posedge sys_clk)
		!sys_rst_n |-> uart_tx_port && led == 8'h00)
		else begin
			$error("serial line or LEDs active during reset");
			fail_cnt++;
		end

	// digit 0 is scanned first and still holds the blank from reset
	a_first_scan: assert property (@(posedge sys_clk)
		$rose(sys_rst_n) |=> seg_choice == 8'hFE && seg_number == 8'hFF)
		else begin
			$error("first scanned digit after reset is not a blank digit 0");
			fail_cnt++;
		end

	a_one_select: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice))
		else begin
			$error("select lines do not have exactly one low bit");
			fail_cnt++;
		end

	a_scan_step: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		seg_choice != choice_q |-> seg_choice == {choice_q[6:0], choice_q[7]}
			&& hold_cnt == `SCAN_CYCLES)
		else begin
			$error("digit select out of order or held for the wrong time");
			fail_cnt++;
		end

endmodule

//--- tb_board_top.sv
/*
 * tb_board_top
 * drives UART frames and bouncing keys into board_top, decodes
 * the serial output and checks LEDs and the scanned display
 */
`timescale 1ns/1ns
`include "board_cfg.svh"

module tb_board_top import board_pkg::*; ();

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic       uart_rx_port;
	logic [7:0] led;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;
	logic       uart_tx_port;

	int          errors = 0;
	logic [15:0] lfsr = 16'd22252;
	byte_t       exp_q [$];
	byte_t       exp_rx = 8'h00;
	byte_t       exp_test = 8'h00;
	logic [3:0]  exp_led = 4'h0;

	// active-high gfedcba patterns for 0..F
	localparam logic [6:0] HEX_SEGS [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
		7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

	board_top DUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.key_in       (key_in),
		.led          (led),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	bind board_top board_props u_props (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.led          (led),
		.seg_number   (seg_number),
		.seg_choice   (seg_choice),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[6:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
		end
		return val;
	endfunction

	function automatic seg_t seg_pattern(input digit_t code);
		logic [6:0] lit;
		if (code < 5'd16)
			lit = HEX_SEGS[code[3:0]];
		else if (code == DIG_DASH)
			lit = 7'h40;
		else
			lit = 7'h00;
		return {1'b1, ~lit};
	endfunction

	// digit 7 is the leftmost one
	function automatic digit_t expected_code(input int idx);
		case (idx)
			7:       return DIG_F;
			5:       return DIG_DASH;
			4:       return {1'b0, exp_test[7:4]};
			3:       return {1'b0, exp_test[3:0]};
			1:       return {1'b0, exp_rx[7:4]};
			0:       return {1'b0, exp_rx[3:0]};
			default: return DIG_BLANK;
		endcase
	endfunction

	task automatic report();
		$display("check errors %0d, assertion failures %0d", errors, DUT.u_props.fail_cnt);
		if (errors == 0 && DUT.u_props.fail_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_digit(input int idx, input digit_t code);
		int cyc;
		cyc = 0;
		while (seg_choice != ~(8'd1 << idx) && cyc < 16 * `SCAN_CYCLES) begin
			@(negedge sys_clk);
			cyc++;
		end
		if (seg_choice != ~(8'd1 << idx)) begin
			errors++;
			$display("timeout, digit %0d was never selected", idx);
			report();
		end else begin
			check_value($sformatf("seg_number digit %0d", idx), seg_number, seg_pattern(code));
		end
	endtask

	task automatic check_display();
		for (int idx = 0; idx < 8; idx++)
			check_digit(idx, expected_code(idx));
	endtask

	task automatic wait_sent();
		int cyc;
		cyc = 0;
		while (exp_q.size() != 0 && cyc < 50 * `BIT_CYCLES) begin
			@(negedge sys_clk);
			cyc++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout, %0d bytes never left uart_tx_port", exp_q.size());
			report();
		end
	endtask

	// start bit, data lsb first, stop bit and one idle bit
	task automatic send_frame(input byte_t data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};
		@(posedge sys_clk);
		for (int i = 0; i < 10; i++) begin
			uart_rx_port <= frame[i];
			repeat (`BIT_CYCLES) @(posedge sys_clk);
		end
		uart_rx_port <= 1'b1;
		repeat (`BIT_CYCLES) @(posedge sys_clk);
	endtask

	// bounce pieces stay shorter than the debounce window
	task automatic press_key(input int k);
		int n;
		n = rand_bits(2) + 1;
		@(posedge sys_clk);
		for (int i = 0; i < 2 * n; i++) begin
			key_in[k] <= i[0];
			repeat (rand_bits(2) + 1) @(posedge sys_clk);
		end
		key_in[k] <= 1'b0;
		repeat (`DEBOUNCE_CYCLES + 5) @(posedge sys_clk);
		// the held key shows on its upper LED
		@(negedge sys_clk);
		check_value("led[7:4]", {4'h0, led[7:4]}, {4'h0, 4'b0001 << k});
		@(posedge sys_clk);
		key_in[k] <= 1'b1;
		repeat (`DEBOUNCE_CYCLES + 6) @(posedge sys_clk);
	endtask

	// serial decoder sampling each bit in its middle
	initial begin : tx_monitor
		byte_t data;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n && !uart_tx_port) begin
				repeat (`BIT_CYCLES / 2) @(negedge sys_clk);
				for (int i = 0; i < 8; i++) begin
					repeat (`BIT_CYCLES) @(negedge sys_clk);
					data[i] = uart_tx_port;
				end
				repeat (`BIT_CYCLES) @(negedge sys_clk);
				check_value("uart_tx_port stop bit", {7'h00, uart_tx_port}, 8'h01);
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected byte %02h on uart_tx_port at %0t", data, $time);
				end else begin
					check_value("uart_tx_port", data, exp_q.pop_front());
				end
			end
		end
	end

	initial begin : stimulus
		byte_t data;
		sys_rst_n    = 1'b1;
		key_in       = 4'hF;
		uart_rx_port = 1'b1;
		#5 sys_rst_n = 1'b0;
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (3) @(negedge sys_clk);
		check_value("led", led, 8'h00);
		check_display();

		// echo of random bytes
		for (int i = 0; i < 4; i++) begin
			data = rand_bits(8);
			exp_q.push_back(data);
			exp_rx = data;
			send_frame(data, 1'b1);
			wait_sent();
			check_display();
		end

		// a low stop bit gets no echo and leaves the display as it was
		send_frame(rand_bits(8), 1'b0);
		repeat (20 * `BIT_CYCLES) @(negedge sys_clk);
		check_display();

		// key 0 sends the running test byte
		for (int i = 0; i < 3; i++) begin
			exp_q.push_back(exp_test);
			press_key(0);
			exp_led[0] = ~exp_led[0];
			wait_sent();
			exp_test++;
			check_value("led", led, {4'h0, exp_led});
			check_display();
		end

		for (int k = 1; k < 4; k++) begin
			press_key(k);
			exp_led[k] = ~exp_led[k];
			repeat (4) @(negedge sys_clk);
			check_value("led", led, {4'h0, exp_led});
		end

		// echo and test byte both pending behind a running test byte
		data = rand_bits(8);
		exp_q.push_back(exp_test);
		exp_q.push_back(data);
		exp_q.push_back(exp_test + 8'd1);
		fork
			send_frame(data, 1'b1);
			begin
				press_key(0);
				press_key(0);
			end
		join
		wait_sent();
		exp_rx = data;
		exp_test = exp_test + 8'd2;
		check_value("led", led, {4'h0, exp_led});
		check_display();
		repeat (12 * `BIT_CYCLES) @(negedge sys_clk);
		report();
	end

endmodule

//--- all.f
+incdir+.
board_pkg.sv
uart_byte_if.sv
uart_rx.sv
uart_tx.sv
key_debounce.sv
uart_echo_ctrl.sv
seg_scan.sv
board_top.sv
board_props.sv
tb_board_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_board_top -f all.f -o sim_board

./obj_dir/sim_board +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
